// ==== source/letc_pkg.sv ====
package letc_pkg;

//Architectural widths for RV32I
localparam int XLEN      = 32;
localparam int REG_IDX_W = 5;
localparam int CSR_IDX_W = 12;

//One machine word, used for register and CSR data
typedef logic [XLEN-1:0] word_t;

//Index into the 32-entry integer register file
typedef logic [REG_IDX_W-1:0] reg_idx_t;

//Address into the 4096-entry CSR space
typedef logic [CSR_IDX_W-1:0] csr_idx_t;

endpackage : letc_pkg

// ==== source/letc_core_pkg.sv ====
package letc_core_pkg;

//Major opcodes, instruction bits [6:0]
localparam logic [6:0] OPCODE_OP     = 7'b0110011;
localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

//funct3 values for register-register ops
localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
localparam logic [2:0] FUNCT3_XOR     = 3'b100;
localparam logic [2:0] FUNCT3_OR      = 3'b110;
localparam logic [2:0] FUNCT3_AND     = 3'b111;

//funct3 for the only immediate op supported
localparam logic [2:0] FUNCT3_ADDI = 3'b000;

//funct3 values under OPCODE_SYSTEM
localparam logic [2:0] FUNCT3_CSRRW = 3'b001;
localparam logic [2:0] FUNCT3_CSRRS = 3'b010;

//funct7 selects between ADD and SUB
localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
localparam logic [6:0] FUNCT7_SUB  = 7'b0100000;

//Single hart, so the hart ID is fixed
localparam logic [31:0] MHARTID_VALUE = 32'h0000_0000;

//Operation carried from D down the pipe
typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_ADDI,
    OP_LUI,
    OP_CSRRW,
    OP_CSRRS,
    OP_ILLEGAL
} op_e;

//Implemented CSR addresses
typedef enum logic [11:0] {
    CSR_MSCRATCH = 12'h340,
    CSR_MHARTID  = 12'hF14
} csr_e;

endpackage : letc_core_pkg

// ==== source/letc_core_rf.sv ====
module letc_core_rf
    import letc_pkg::*;
(
    //Clock and reset
    input  logic     i_clk,
    input  logic     i_arst_n,

    //rd write port
    input  reg_idx_t i_rd_idx,
    input  word_t    i_rd_wdata,
    input  logic     i_rd_wen,

    //rs1 read port
    input  reg_idx_t i_rs1_idx,
    output word_t    o_rs1_rdata,

    //rs2 read port
    input  reg_idx_t i_rs2_idx,
    output word_t    o_rs2_rdata
);

//x1 through x31, x0 has no storage
word_t regs [1:31];

//Single write port, commits at the edge
always_ff @(posedge i_clk) begin
    if (i_rd_wen && (i_rd_idx != '0)) begin
        regs[i_rd_idx] <= i_rd_wdata;
    end
end

//Asynchronous reads, x0 reads as zero
assign o_rs1_rdata = (i_rs1_idx == '0) ? '0 : regs[i_rs1_idx];
assign o_rs2_rdata = (i_rs2_idx == '0) ? '0 : regs[i_rs2_idx];

//W must never present a write with a floating index
assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_rd_wen |-> !$isunknown(i_rd_idx));

endmodule : letc_core_rf

// ==== source/letc_core_stage_d.sv ====
module letc_core_stage_d
    import letc_pkg::*;
    import letc_core_pkg::*;
(
    //Clock and reset
    input  logic     i_clk,
    input  logic     i_arst_n,

    //Instruction input
    input  logic     i_instr_valid,
    input  word_t    i_instr,

    //Register file reads
    output reg_idx_t o_rs1_idx,
    input  word_t    i_rs1_rdata,
    output reg_idx_t o_rs2_idx,
    input  word_t    i_rs2_rdata,

    //Bypass from the hazard unit
    input  logic     i_bypass_rs1,
    input  logic     i_bypass_rs2,
    input  word_t    i_bypass_rs1_rdata,
    input  word_t    i_bypass_rs2_rdata,

    //To E
    output logic     o_de_valid,
    output op_e      o_de_op,
    output reg_idx_t o_de_rd_idx,
    output logic     o_de_rd_wen,
    output word_t    o_de_rs1_rdata,
    output word_t    o_de_rs2_rdata,
    output word_t    o_de_imm,
    output csr_idx_t o_de_csr_idx
);

//Instruction fields
logic [6:0] opcode;
logic [2:0] funct3;
logic [6:0] funct7;
reg_idx_t   rd_idx;
op_e        op;
word_t      imm;
word_t      rs1_val;
word_t      rs2_val;

assign opcode    = i_instr[6:0];
assign rd_idx    = i_instr[11:7];
assign funct3    = i_instr[14:12];
assign o_rs1_idx = i_instr[19:15];
assign o_rs2_idx = i_instr[24:20];
assign funct7    = i_instr[31:25];

//Decode, anything unmatched is illegal
always_comb begin
    op  = OP_ILLEGAL;
    imm = '0;
    case (opcode)
        OPCODE_OP: begin
            if (funct7 == FUNCT7_BASE) begin
                case (funct3)
                    FUNCT3_ADD_SUB: op = OP_ADD;
                    FUNCT3_XOR:     op = OP_XOR;
                    FUNCT3_OR:      op = OP_OR;
                    FUNCT3_AND:     op = OP_AND;
                    default:        op = OP_ILLEGAL;
                endcase
            end else if ((funct7 == FUNCT7_SUB) && (funct3 == FUNCT3_ADD_SUB)) begin
                op = OP_SUB;
            end
        end
        OPCODE_OP_IMM: begin
            //I-type, sign extended
            imm = {{20{i_instr[31]}}, i_instr[31:20]};
            if (funct3 == FUNCT3_ADDI) begin
                op = OP_ADDI;
            end
        end
        OPCODE_LUI: begin
            //U-type, low 12 bits zero
            imm = {i_instr[31:12], 12'h000};
            op  = OP_LUI;
        end
        OPCODE_SYSTEM: begin
            //uimm field carries the rs1 index so E can spot CSRRS with x0
            imm = {27'd0, o_rs1_idx};
            if (funct3 == FUNCT3_CSRRW) begin
                op = OP_CSRRW;
            end else if (funct3 == FUNCT3_CSRRS) begin
                op = OP_CSRRS;
            end
        end
        default: op = OP_ILLEGAL;
    endcase
end

//Bypassed value wins over the stale register file copy
assign rs1_val = i_bypass_rs1 ? i_bypass_rs1_rdata : i_rs1_rdata;
assign rs2_val = i_bypass_rs2 ? i_bypass_rs2_rdata : i_rs2_rdata;

//Control into E
always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
        o_de_valid  <= 1'b0;
        o_de_rd_wen <= 1'b0;
        o_de_op     <= OP_ILLEGAL;
    end else begin
        o_de_valid  <= i_instr_valid;
        //Illegal ops and x0 never write
        o_de_rd_wen <= i_instr_valid && (op != OP_ILLEGAL) && (rd_idx != '0);
        o_de_op     <= op;
    end
end

//Payload into E
always_ff @(posedge i_clk) begin
    o_de_rd_idx    <= rd_idx;
    o_de_rs1_rdata <= rs1_val;
    o_de_rs2_rdata <= rs2_val;
    o_de_imm       <= imm;
    o_de_csr_idx   <= i_instr[31:20];
end

endmodule : letc_core_stage_d

// ==== source/letc_core_stage_e.sv ====
module letc_core_stage_e
    import letc_pkg::*;
    import letc_core_pkg::*;
(
    //Clock and reset
    input  logic     i_clk,
    input  logic     i_arst_n,

    //From D
    input  logic     i_de_valid,
    input  op_e      i_de_op,
    input  reg_idx_t i_de_rd_idx,
    input  logic     i_de_rd_wen,
    input  word_t    i_de_rs1_rdata,
    input  word_t    i_de_rs2_rdata,
    input  word_t    i_de_imm,
    input  csr_idx_t i_de_csr_idx,

    //CSR read and write ports
    output logic     o_csr_ren,
    output csr_idx_t o_csr_idx,
    input  word_t    i_csr_rdata,
    input  logic     i_csr_rill,
    output logic     o_csr_wen,
    output word_t    o_csr_wdata,
    input  logic     i_csr_will,

    //To the hazard unit
    output logic     o_e_valid,
    output logic     o_e_rd_wen,
    output reg_idx_t o_e_rd_idx,
    output word_t    o_e_result,

    //To W
    output logic     o_ew_valid,
    output logic     o_ew_illegal,
    output reg_idx_t o_ew_rd_idx,
    output logic     o_ew_rd_wen,
    output word_t    o_ew_result
);

logic is_csr;
logic illegal;

assign is_csr = (i_de_op == OP_CSRRW) || (i_de_op == OP_CSRRS);

//CSR access, both read and write resolve here
assign o_csr_ren   = i_de_valid && is_csr;
assign o_csr_idx   = i_de_csr_idx;
//CSRRS with rs1 = x0 is a pure read
assign o_csr_wen   = i_de_valid && ((i_de_op == OP_CSRRW) ||
                     ((i_de_op == OP_CSRRS) && (i_de_imm[4:0] != 5'd0)));
assign o_csr_wdata = (i_de_op == OP_CSRRW) ? i_de_rs1_rdata : (i_csr_rdata | i_de_rs1_rdata);

//Bad encoding or a refused CSR access
assign illegal = (i_de_op == OP_ILLEGAL) || i_csr_rill || i_csr_will;

//ALU
always_comb begin
    case (i_de_op)
        OP_ADD:   o_e_result = i_de_rs1_rdata + i_de_rs2_rdata;
        OP_SUB:   o_e_result = i_de_rs1_rdata - i_de_rs2_rdata;
        OP_AND:   o_e_result = i_de_rs1_rdata & i_de_rs2_rdata;
        OP_OR:    o_e_result = i_de_rs1_rdata | i_de_rs2_rdata;
        OP_XOR:   o_e_result = i_de_rs1_rdata ^ i_de_rs2_rdata;
        OP_ADDI:  o_e_result = i_de_rs1_rdata + i_de_imm;
        OP_LUI:   o_e_result = i_de_imm;
        //Old CSR value goes to rd
        OP_CSRRW: o_e_result = i_csr_rdata;
        OP_CSRRS: o_e_result = i_csr_rdata;
        default:  o_e_result = '0;
    endcase
end

//Only a real pending write is offered for bypass
assign o_e_valid  = i_de_valid;
assign o_e_rd_wen = i_de_valid && i_de_rd_wen && !illegal;
assign o_e_rd_idx = i_de_rd_idx;

//Control into W
always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
        o_ew_valid   <= 1'b0;
        o_ew_illegal <= 1'b0;
        o_ew_rd_wen  <= 1'b0;
    end else begin
        o_ew_valid   <= i_de_valid;
        o_ew_illegal <= i_de_valid && illegal;
        o_ew_rd_wen  <= i_de_valid && i_de_rd_wen;
    end
end

//Payload into W
always_ff @(posedge i_clk) begin
    o_ew_rd_idx <= i_de_rd_idx;
    o_ew_result <= o_e_result;
end

endmodule : letc_core_stage_e

// ==== source/letc_core_stage_w.sv ====
module letc_core_stage_w
    import letc_pkg::*;
(
    //From E
    input  logic     i_ew_valid,
    input  logic     i_ew_illegal,
    input  reg_idx_t i_ew_rd_idx,
    input  logic     i_ew_rd_wen,
    input  word_t    i_ew_result,

    //Register file write port
    output reg_idx_t o_rd_idx,
    output word_t    o_rd_wdata,
    output logic     o_rd_wen,

    //Retire trace
    output logic     o_retire_valid,
    output logic     o_retire_illegal,
    output logic     o_retire_rd_wen,
    output reg_idx_t o_retire_rd_idx,
    output word_t    o_retire_rd_wdata
);

//Write only for a valid, legal instruction
assign o_rd_wen   = i_ew_valid && !i_ew_illegal && i_ew_rd_wen;
assign o_rd_idx   = i_ew_rd_idx;
assign o_rd_wdata = i_ew_result;

//Trace mirrors what is committed this cycle
assign o_retire_valid    = i_ew_valid;
assign o_retire_illegal  = i_ew_valid && i_ew_illegal;
assign o_retire_rd_wen   = o_rd_wen;
assign o_retire_rd_idx   = i_ew_rd_idx;
assign o_retire_rd_wdata = i_ew_result;

endmodule : letc_core_stage_w

// ==== source/letc_core_csr.sv ====
module letc_core_csr
    import letc_pkg::*;
    import letc_core_pkg::*;
(
    //Clock and reset
    input  logic     i_clk,
    input  logic     i_arst_n,

    //Explicit read port
    input  logic     i_csr_ren,
    input  csr_idx_t i_csr_idx,
    output word_t    o_csr_rdata,
    output logic     o_csr_rill,

    //Explicit write port sharing the read index
    input  logic     i_csr_wen,
    input  word_t    i_csr_wdata,
    output logic     o_csr_will
);

word_t mscratch;
csr_e  csr_sel;
logic  csr_known;

assign csr_sel = csr_e'(i_csr_idx);

//Read mux
always_comb begin
    case (csr_sel)
        CSR_MSCRATCH: begin
            o_csr_rdata = mscratch;
            csr_known   = 1'b1;
        end
        CSR_MHARTID: begin
            o_csr_rdata = MHARTID_VALUE;
            csr_known   = 1'b1;
        end
        default: begin
            o_csr_rdata = '0;
            csr_known   = 1'b0;
        end
    endcase
end

//Unknown address cannot be read
assign o_csr_rill = i_csr_ren && !csr_known;
//mscratch is the only writable CSR
assign o_csr_will = i_csr_wen && (csr_sel != CSR_MSCRATCH);

//Commit at the end of E
always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
        mscratch <= '0;
    end else if (i_csr_wen && !o_csr_will) begin
        mscratch <= i_csr_wdata;
    end
end

//CSRRW and CSRRS both read the CSR they write
assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_csr_wen |-> i_csr_ren);

endmodule : letc_core_csr

// ==== source/letc_core_tghm.sv ====
module letc_core_tghm
    import letc_pkg::*;
(
    //Sources of the instruction in D
    input  reg_idx_t i_rs1_idx,
    input  reg_idx_t i_rs2_idx,

    //Instruction in E with its unregistered result
    input  logic     i_e_valid,
    input  logic     i_e_rd_wen,
    input  reg_idx_t i_e_rd_idx,
    input  word_t    i_e_result,

    //Instruction in W whose write lands at the next edge
    input  logic     i_w_rd_wen,
    input  reg_idx_t i_w_rd_idx,
    input  word_t    i_w_rd_wdata,

    //Bypass to D
    output logic     o_bypass_rs1,
    output logic     o_bypass_rs2,
    output word_t    o_bypass_rs1_rdata,
    output word_t    o_bypass_rs2_rdata
);

logic e_fwd;

//E carries the younger write
assign e_fwd = i_e_valid && i_e_rd_wen;

always_comb begin
    o_bypass_rs1       = 1'b0;
    o_bypass_rs2       = 1'b0;
    o_bypass_rs1_rdata = i_w_rd_wdata;
    o_bypass_rs2_rdata = i_w_rd_wdata;

    //rs1 checks E before W and skips x0
    if (i_rs1_idx != '0) begin
        if (e_fwd && (i_e_rd_idx == i_rs1_idx)) begin
            o_bypass_rs1       = 1'b1;
            o_bypass_rs1_rdata = i_e_result;
        end else if (i_w_rd_wen && (i_w_rd_idx == i_rs1_idx)) begin
            o_bypass_rs1 = 1'b1;
        end
    end

    //rs2 uses the same priority
    if (i_rs2_idx != '0) begin
        if (e_fwd && (i_e_rd_idx == i_rs2_idx)) begin
            o_bypass_rs2       = 1'b1;
            o_bypass_rs2_rdata = i_e_result;
        end else if (i_w_rd_wen && (i_w_rd_idx == i_rs2_idx)) begin
            o_bypass_rs2 = 1'b1;
        end
    end
end

endmodule : letc_core_tghm

// ==== source/letc_core_top.sv ====
module letc_core_top
    import letc_pkg::*;
    import letc_core_pkg::*;
(
    //Clock and reset
    input  logic     i_clk,
    input  logic     i_arst_n,

    //Instruction input
    input  logic     i_instr_valid,
    input  word_t    i_instr,

    //Retire trace
    output logic     o_retire_valid,
    output logic     o_retire_illegal,
    output logic     o_retire_rd_wen,
    output reg_idx_t o_retire_rd_idx,
    output word_t    o_retire_rd_wdata
);

//Register file ports
reg_idx_t rs1_idx;
word_t    rs1_rdata;
reg_idx_t rs2_idx;
word_t    rs2_rdata;
reg_idx_t rd_idx;
word_t    rd_wdata;
logic     rd_wen;

//Bypass into D
logic  bypass_rs1;
logic  bypass_rs2;
word_t bypass_rs1_rdata;
word_t bypass_rs2_rdata;

//D to E
logic     de_valid;
op_e      de_op;
reg_idx_t de_rd_idx;
logic     de_rd_wen;
word_t    de_rs1_rdata;
word_t    de_rs2_rdata;
word_t    de_imm;
csr_idx_t de_csr_idx;

//E result seen by the hazard unit
logic     e_valid;
logic     e_rd_wen;
reg_idx_t e_rd_idx;
word_t    e_result;

//E to W
logic     ew_valid;
logic     ew_illegal;
reg_idx_t ew_rd_idx;
logic     ew_rd_wen;
word_t    ew_result;

//CSR access from E
logic     csr_ren;
csr_idx_t csr_idx;
word_t    csr_rdata;
logic     csr_rill;
logic     csr_wen;
word_t    csr_wdata;
logic     csr_will;

letc_core_rf rf (
    .i_clk(i_clk),
    .i_arst_n(i_arst_n),
    .i_rd_idx(rd_idx),
    .i_rd_wdata(rd_wdata),
    .i_rd_wen(rd_wen),
    .i_rs1_idx(rs1_idx),
    .o_rs1_rdata(rs1_rdata),
    .i_rs2_idx(rs2_idx),
    .o_rs2_rdata(rs2_rdata)
);

letc_core_stage_d stage_d (
    .i_clk(i_clk),
    .i_arst_n(i_arst_n),
    .i_instr_valid(i_instr_valid),
    .i_instr(i_instr),
    .o_rs1_idx(rs1_idx),
    .i_rs1_rdata(rs1_rdata),
    .o_rs2_idx(rs2_idx),
    .i_rs2_rdata(rs2_rdata),
    .i_bypass_rs1(bypass_rs1),
    .i_bypass_rs2(bypass_rs2),
    .i_bypass_rs1_rdata(bypass_rs1_rdata),
    .i_bypass_rs2_rdata(bypass_rs2_rdata),
    .o_de_valid(de_valid),
    .o_de_op(de_op),
    .o_de_rd_idx(de_rd_idx),
    .o_de_rd_wen(de_rd_wen),
    .o_de_rs1_rdata(de_rs1_rdata),
    .o_de_rs2_rdata(de_rs2_rdata),
    .o_de_imm(de_imm),
    .o_de_csr_idx(de_csr_idx)
);

letc_core_stage_e stage_e (
    .i_clk(i_clk),
    .i_arst_n(i_arst_n),
    .i_de_valid(de_valid),
    .i_de_op(de_op),
    .i_de_rd_idx(de_rd_idx),
    .i_de_rd_wen(de_rd_wen),
    .i_de_rs1_rdata(de_rs1_rdata),
    .i_de_rs2_rdata(de_rs2_rdata),
    .i_de_imm(de_imm),
    .i_de_csr_idx(de_csr_idx),
    .o_csr_ren(csr_ren),
    .o_csr_idx(csr_idx),
    .i_csr_rdata(csr_rdata),
    .i_csr_rill(csr_rill),
    .o_csr_wen(csr_wen),
    .o_csr_wdata(csr_wdata),
    .i_csr_will(csr_will),
    .o_e_valid(e_valid),
    .o_e_rd_wen(e_rd_wen),
    .o_e_rd_idx(e_rd_idx),
    .o_e_result(e_result),
    .o_ew_valid(ew_valid),
    .o_ew_illegal(ew_illegal),
    .o_ew_rd_idx(ew_rd_idx),
    .o_ew_rd_wen(ew_rd_wen),
    .o_ew_result(ew_result)
);

letc_core_stage_w stage_w (
    .i_ew_valid(ew_valid),
    .i_ew_illegal(ew_illegal),
    .i_ew_rd_idx(ew_rd_idx),
    .i_ew_rd_wen(ew_rd_wen),
    .i_ew_result(ew_result),
    .o_rd_idx(rd_idx),
    .o_rd_wdata(rd_wdata),
    .o_rd_wen(rd_wen),
    .o_retire_valid(o_retire_valid),
    .o_retire_illegal(o_retire_illegal),
    .o_retire_rd_wen(o_retire_rd_wen),
    .o_retire_rd_idx(o_retire_rd_idx),
    .o_retire_rd_wdata(o_retire_rd_wdata)
);

letc_core_csr csr (
    .i_clk(i_clk),
    .i_arst_n(i_arst_n),
    .i_csr_ren(csr_ren),
    .i_csr_idx(csr_idx),
    .o_csr_rdata(csr_rdata),
    .o_csr_rill(csr_rill),
    .i_csr_wen(csr_wen),
    .i_csr_wdata(csr_wdata),
    .o_csr_will(csr_will)
);

//W side taps the register file write port
letc_core_tghm tghm (
    .i_rs1_idx(rs1_idx),
    .i_rs2_idx(rs2_idx),
    .i_e_valid(e_valid),
    .i_e_rd_wen(e_rd_wen),
    .i_e_rd_idx(e_rd_idx),
    .i_e_result(e_result),
    .i_w_rd_wen(rd_wen),
    .i_w_rd_idx(rd_idx),
    .i_w_rd_wdata(rd_wdata),
    .o_bypass_rs1(bypass_rs1),
    .o_bypass_rs2(bypass_rs2),
    .o_bypass_rs1_rdata(bypass_rs1_rdata),
    .o_bypass_rs2_rdata(bypass_rs2_rdata)
);

endmodule : letc_core_top

// ==== dv/letc_core_checker.sv ====
module letc_core_checker (
    //Clock and reset
    input  logic        i_clk,
    input  logic        i_arst_n,

    //Expected entry, one per instruction sent
    input  logic        i_exp_push,
    input  logic        i_exp_illegal,
    input  logic        i_exp_rd_wen,
    input  logic [4:0]  i_exp_rd_idx,
    input  logic [31:0] i_exp_rd_wdata,

    //Retire trace from the DUT
    input  logic        i_retire_valid,
    input  logic        i_retire_illegal,
    input  logic        i_retire_rd_wen,
    input  logic [4:0]  i_retire_rd_idx,
    input  logic [31:0] i_retire_rd_wdata,

    //Running totals
    output int          o_retired,
    output int          o_errors,
    output int          o_pending
);

timeunit 1ns;
timeprecision 1ps;

//Outstanding expectations, oldest first
logic        exp_illegal_q [$];
logic        exp_rd_wen_q [$];
logic [4:0]  exp_rd_idx_q [$];
logic [31:0] exp_rd_wdata_q [$];

int retired;
int errors;

assign o_retired = retired;
assign o_errors  = errors;
assign o_pending = exp_illegal_q.size();

initial begin
    retired = 0;
    errors  = 0;
end

//One field, X on the DUT side counts as wrong
task automatic compare_field(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
        $display("Mismatch at %0t ns: %s expected 0x%08h, got 0x%08h",
                 $time, name, expected, actual);
        errors++;
    end
endtask

//Pops the oldest expectation and compares the trace against it
task automatic check_retire();
    logic        exp_illegal;
    logic        exp_rd_wen;
    logic [4:0]  exp_rd_idx;
    logic [31:0] exp_rd_wdata;
    int          errors_before;
    if (exp_illegal_q.size() == 0) begin
        $display("[%0t ns] A retire arrived while no instruction was outstanding", $time);
        errors++;
    end else begin
        exp_illegal   = exp_illegal_q.pop_front();
        exp_rd_wen    = exp_rd_wen_q.pop_front();
        exp_rd_idx    = exp_rd_idx_q.pop_front();
        exp_rd_wdata  = exp_rd_wdata_q.pop_front();
        errors_before = errors;
        compare_field("o_retire_illegal", 32'(exp_illegal), 32'(i_retire_illegal));
        compare_field("o_retire_rd_wen", 32'(exp_rd_wen), 32'(i_retire_rd_wen));
        //Index and data only mean something with a write
        if (exp_rd_wen) begin
            compare_field("o_retire_rd_idx", 32'(exp_rd_idx), 32'(i_retire_rd_idx));
            compare_field("o_retire_rd_wdata", exp_rd_wdata, i_retire_rd_wdata);
        end
        if (errors == errors_before) begin
            $display("[%0t ns] instr %0d ok", $time, retired);
        end else begin
            $display("[%0t ns] instr %0d wrong", $time, retired);
        end
    end
    retired++;
endtask

//Sampled at the edge, so both DUT and driver values are settled
always @(posedge i_clk) begin
    if (i_arst_n) begin
        if (i_retire_valid) begin
            check_retire();
        end
        if (i_exp_push) begin
            exp_illegal_q.push_back(i_exp_illegal);
            exp_rd_wen_q.push_back(i_exp_rd_wen);
            exp_rd_idx_q.push_back(i_exp_rd_idx);
            exp_rd_wdata_q.push_back(i_exp_rd_wdata);
        end
    end
end

endmodule : letc_core_checker

// ==== dv/letc_core_tb.sv ====
module letc_core_tb;

timeunit 1ns;
timeprecision 1ps;

localparam int NUM_TESTS      = 24;
//Worst case is two idle cycles per instruction plus pipe latency and reset
localparam int TIMEOUT_CYCLES = NUM_TESTS * 3 + 20;

//DUT inputs
logic        clk;
logic        arst_n;
logic        instr_valid;
logic [31:0] instr;

//Retire trace
logic        retire_valid;
logic        retire_illegal;
logic        retire_rd_wen;
logic [4:0]  retire_rd_idx;
logic [31:0] retire_rd_wdata;

//Expected entry for the checker
logic        exp_push;
logic        exp_illegal;
logic        exp_rd_wen;
logic [4:0]  exp_rd_idx;
logic [31:0] exp_rd_wdata;

int retired;
int errors;
int pending;

//Instruction table with expected retire values
logic [31:0] tbl_instr [NUM_TESTS];
logic        tbl_illegal [NUM_TESTS];
logic        tbl_rd_wen [NUM_TESTS];
logic [4:0]  tbl_rd_idx [NUM_TESTS];
logic [31:0] tbl_rd_wdata [NUM_TESTS];
int          num_entries;

logic [31:0] rng_state;
logic [1:0]  gap;

letc_core_top uut (
    .i_clk(clk),
    .i_arst_n(arst_n),
    .i_instr_valid(instr_valid),
    .i_instr(instr),
    .o_retire_valid(retire_valid),
    .o_retire_illegal(retire_illegal),
    .o_retire_rd_wen(retire_rd_wen),
    .o_retire_rd_idx(retire_rd_idx),
    .o_retire_rd_wdata(retire_rd_wdata)
);

letc_core_checker checker_inst (
    .i_clk(clk),
    .i_arst_n(arst_n),
    .i_exp_push(exp_push),
    .i_exp_illegal(exp_illegal),
    .i_exp_rd_wen(exp_rd_wen),
    .i_exp_rd_idx(exp_rd_idx),
    .i_exp_rd_wdata(exp_rd_wdata),
    .i_retire_valid(retire_valid),
    .i_retire_illegal(retire_illegal),
    .i_retire_rd_wen(retire_rd_wen),
    .i_retire_rd_idx(retire_rd_idx),
    .i_retire_rd_wdata(retire_rd_wdata),
    .o_retired(retired),
    .o_errors(errors),
    .o_pending(pending)
);

//RV32I encoders
function automatic logic [31:0] encode_r_type(input logic [6:0] funct7, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] funct3,
                                              input logic [4:0] rd);
    return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] encode_addi(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [4:0] rd);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
endfunction

function automatic logic [31:0] encode_lui(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111};
endfunction

function automatic logic [31:0] encode_csr(input logic [11:0] csr, input logic [4:0] rs1,
                                           input logic [2:0] funct3, input logic [4:0] rd);
    return {csr, rs1, funct3, rd, 7'b1110011};
endfunction

//Simple LCG for the idle gaps
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

task automatic add_table_entry(input logic [31:0] word, input logic illegal, input logic wen,
                               input logic [4:0] rd, input logic [31:0] wdata);
    tbl_instr[num_entries]    = word;
    tbl_illegal[num_entries]  = illegal;
    tbl_rd_wen[num_entries]   = wen;
    tbl_rd_idx[num_entries]   = rd;
    tbl_rd_wdata[num_entries] = wdata;
    num_entries++;
endtask

task automatic fill_table();
    num_entries = 0;
    //Constants and back-to-back dependent ALU ops
    add_table_entry(encode_addi(12'd5, 5'd0, 5'd1), 1'b0, 1'b1, 5'd1, 32'h0000_0005);
    add_table_entry(encode_addi(12'hFFD, 5'd0, 5'd2), 1'b0, 1'b1, 5'd2, 32'hFFFF_FFFD);
    add_table_entry(encode_r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 1'b0, 1'b1, 5'd3, 32'h2);
    add_table_entry(encode_lui(20'h12345, 5'd4), 1'b0, 1'b1, 5'd4, 32'h1234_5000);
    add_table_entry(encode_r_type(7'h20, 5'd3, 5'd4, 3'b000, 5'd5), 1'b0, 1'b1, 5'd5,
                    32'h1234_4FFE);
    add_table_entry(encode_r_type(7'h00, 5'd4, 5'd5, 3'b111, 5'd6), 1'b0, 1'b1, 5'd6,
                    32'h1234_4000);
    add_table_entry(encode_r_type(7'h00, 5'd1, 5'd6, 3'b110, 5'd7), 1'b0, 1'b1, 5'd7,
                    32'h1234_4005);
    add_table_entry(encode_r_type(7'h00, 5'd2, 5'd7, 3'b100, 5'd8), 1'b0, 1'b1, 5'd8,
                    32'hEDCB_BFF8);
    //Write to x0 is dropped and x0 still reads zero
    add_table_entry(encode_addi(12'd7, 5'd1, 5'd0), 1'b0, 1'b0, 5'd0, 32'h0);
    add_table_entry(encode_r_type(7'h00, 5'd1, 5'd0, 3'b000, 5'd9), 1'b0, 1'b1, 5'd9, 32'h5);
    //mscratch swap and bit set with pure reads between
    add_table_entry(encode_csr(12'h340, 5'd7, 3'b001, 5'd10), 1'b0, 1'b1, 5'd10, 32'h0);
    add_table_entry(encode_csr(12'h340, 5'd3, 3'b010, 5'd11), 1'b0, 1'b1, 5'd11, 32'h1234_4005);
    add_table_entry(encode_csr(12'h340, 5'd0, 3'b010, 5'd12), 1'b0, 1'b1, 5'd12, 32'h1234_4007);
    add_table_entry(encode_csr(12'h340, 5'd9, 3'b001, 5'd13), 1'b0, 1'b1, 5'd13, 32'h1234_4007);
    add_table_entry(encode_csr(12'h340, 5'd0, 3'b010, 5'd14), 1'b0, 1'b1, 5'd14, 32'h5);
    //mhartid reads zero while writes and unknown CSRs are illegal
    add_table_entry(encode_csr(12'hF14, 5'd0, 3'b010, 5'd15), 1'b0, 1'b1, 5'd15, 32'h0);
    add_table_entry(encode_csr(12'hF14, 5'd1, 3'b001, 5'd16), 1'b1, 1'b0, 5'd16, 32'h0);
    add_table_entry(encode_csr(12'h7C0, 5'd0, 3'b010, 5'd17), 1'b1, 1'b0, 5'd17, 32'h0);
    //Bad opcode aimed at x1 leaves x1 intact
    add_table_entry(32'h0000_00FF, 1'b1, 1'b0, 5'd1, 32'h0);
    add_table_entry(encode_r_type(7'h00, 5'd0, 5'd1, 3'b000, 5'd18), 1'b0, 1'b1, 5'd18, 32'h5);
    //OR with the SUB funct7 is illegal and x2 keeps -3
    add_table_entry(encode_r_type(7'h20, 5'd1, 5'd1, 3'b110, 5'd2), 1'b1, 1'b0, 5'd2, 32'h0);
    add_table_entry(encode_r_type(7'h00, 5'd3, 5'd2, 3'b000, 5'd19), 1'b0, 1'b1, 5'd19,
                    32'hFFFF_FFFF);
    add_table_entry(encode_r_type(7'h00, 5'd19, 5'd19, 3'b000, 5'd20), 1'b0, 1'b1, 5'd20,
                    32'hFFFF_FFFE);
    add_table_entry(encode_csr(12'h340, 5'd20, 3'b001, 5'd21), 1'b0, 1'b1, 5'd21, 32'h5);
endtask

initial begin
    clk = 1'b0;
    forever begin
        #10 clk = ~clk;
    end
end

//Watchdog
initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles with %0d of %0d instructions retired",
             TIMEOUT_CYCLES, retired, NUM_TESTS);
    $display("Test failed");
    $finish;
end

initial begin
    arst_n       = 1'b0;
    instr_valid  = 1'b0;
    instr        = '0;
    exp_push     = 1'b0;
    exp_illegal  = 1'b0;
    exp_rd_wen   = 1'b0;
    exp_rd_idx   = '0;
    exp_rd_wdata = '0;
    rng_state    = 32'h4721983f;
    fill_table();

    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);

    for (int i = 0; i < NUM_TESTS; i++) begin
        instr_valid  <= 1'b1;
        instr        <= tbl_instr[i];
        exp_push     <= 1'b1;
        exp_illegal  <= tbl_illegal[i];
        exp_rd_wen   <= tbl_rd_wen[i];
        exp_rd_idx   <= tbl_rd_idx[i];
        exp_rd_wdata <= tbl_rd_wdata[i];
        @(posedge clk);
        //Zero to two idle cycles before the next one
        rng_state = lcg_next(rng_state);
        gap       = 2'(rng_state[31:16] % 16'd3);
        repeat (gap) begin
            instr_valid <= 1'b0;
            exp_push    <= 1'b0;
            @(posedge clk);
        end
    end
    instr_valid <= 1'b0;
    exp_push    <= 1'b0;

    //Wait until every instruction has retired
    while (retired < NUM_TESTS) begin
        @(posedge clk);
    end
    //Catch any stray retire past the two-cycle latency
    repeat (3) @(posedge clk);
    @(negedge clk);

    if (pending != 0) begin
        $display("%0d expected retirements never arrived", pending);
    end
    $display("Summary: %0d retired, %0d expected, %0d errors", retired, NUM_TESTS, errors);
    if ((errors == 0) && (pending == 0) && (retired == NUM_TESTS)) begin
        $display("Test passed");
    end else begin
        $display("Test failed");
    end
    $finish;
end

endmodule : letc_core_tb

// ==== letc_core.f ====
source/letc_pkg.sv
source/letc_core_pkg.sv
source/letc_core_rf.sv
source/letc_core_stage_d.sv
source/letc_core_stage_e.sv
source/letc_core_stage_w.sv
source/letc_core_csr.sv
source/letc_core_tghm.sv
source/letc_core_top.sv
dv/letc_core_checker.sv
dv/letc_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the letc_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
    -f letc_core.f --top-module letc_core_tb -o letc_core_sim

out=$(./obj_dir/letc_core_sim)
echo "$out"

# Non-zero exit unless the pass line is present
echo "$out" | grep -qx "Test passed"
